// File: Makefile
VERILATOR ?= verilator
TOP       ?= csr_unit_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

SRCS := $(wildcard logic/*.sv dv/*.sv)

.PHONY: all run build lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST) dv/csr_input.txt
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q -F '*** FAILED ***' $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q -F '*** PASSED ***' $(LOG) || (echo "no pass message in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/csr_checker.sv
`timescale 1ns/1ps

module csr_checker (
  input  logic                     clk_i,
  input  logic                     rst_i,
  // one expectation strobe per expected response
  input  logic                     exp_push_i,
  input  logic [2:0]               exp_kind_i,
  input  logic [15:0]              exp_id_i,
  input  logic [csr_pkg::XLEN-1:0] exp_data_i,
  input  logic                     exp_illegal_i,
  input  logic                     exp_written_i,
  // DUT outputs
  input  logic                     done_i,
  input  csr_pkg::csr_rsp_t        rsp_i,
  input  csr_pkg::redirect_t       redirect_i,
  input  logic                     busy_i,
  output logic [31:0]              err_count_o,
  output logic [31:0]              pending_o
);
  import csr_pkg::*;

  // kind 1 is an access, 2 a trap, 3 an mret, 5 and 6 the two mcycle reads
  typedef struct packed {
    logic [2:0]      kind;
    logic [15:0]     id;
    logic [XLEN-1:0] data;
    logic            illegal;
    logic            written;
  } expect_t;

  expect_t         exp_q[$];
  expect_t         incoming;
  expect_t         cur;
  logic [XLEN-1:0] cycle_mark;
  logic [XLEN-1:0] cycle_delta;

  task automatic compare_value(input string what, input logic [XLEN-1:0] exp_val,
                               input logic [XLEN-1:0] act_val);
    if (exp_val !== act_val) begin
      $display("mismatch step %0d %s: expected %h, actual %h", cur.id, what, exp_val, act_val);
      err_count_o = err_count_o + 1;
    end
  endtask

  task automatic protocol_error(input string what);
    $display("step %0d: %s", cur.id, what);
    err_count_o = err_count_o + 1;
  endtask

  //////////////////////////////////////////////////
  // per kind comparison
  //////////////////////////////////////////////////

  task automatic check_response();
    case (cur.kind)
      3'd1: begin
        if (!done_i || redirect_i.valid) begin
          protocol_error("csr access ended without done or with a redirect");
        end
        // the write cycle of an access still counts as busy
        if (!busy_i) begin
          protocol_error("unit was not busy while the access completed");
        end
        compare_value("rdata", cur.data, rsp_i.rdata);
        compare_value("illegal", {31'd0, cur.illegal}, {31'd0, rsp_i.illegal});
        compare_value("written", {31'd0, cur.written}, {31'd0, rsp_i.written});
      end
      3'd2: begin
        if (!redirect_i.valid || done_i) begin
          protocol_error("trap entry gave no redirect or an unexpected done");
        end
        compare_value("trap redirect pc", cur.data, redirect_i.pc);
      end
      3'd3: begin
        // mret completes and redirects in the same cycle
        if (!redirect_i.valid || !done_i) begin
          protocol_error("mret needs both done and a redirect");
        end
        compare_value("mret redirect pc", cur.data, redirect_i.pc);
        compare_value("mret rdata", '0, rsp_i.rdata);
      end
      3'd5: begin
        cycle_mark = rsp_i.rdata;
        compare_value("mcycle illegal", '0, {31'd0, rsp_i.illegal});
      end
      3'd6: begin
        cycle_delta = rsp_i.rdata - cycle_mark;
        if (cycle_delta < cur.data) begin
          $display("mismatch step %0d mcycle delta: expected at least %0d, actual %0d",
                   cur.id, cur.data, cycle_delta);
          err_count_o = err_count_o + 1;
        end
      end
      default: protocol_error("expectation of unknown kind");
    endcase
  endtask

  always @(posedge clk_i) begin
    if (rst_i) begin
      exp_q.delete();
      err_count_o = '0;
    end else begin
      if (exp_push_i) begin
        incoming.kind    = exp_kind_i;
        incoming.id      = exp_id_i;
        incoming.data    = exp_data_i;
        incoming.illegal = exp_illegal_i;
        incoming.written = exp_written_i;
        exp_q.push_back(incoming);
      end
      if (done_i || redirect_i.valid) begin
        if (exp_q.size() == 0) begin
          $display("DUT produced a response that nothing was waiting for");
          err_count_o = err_count_o + 1;
        end else begin
          cur = exp_q.pop_front();
          check_response();
        end
      end
    end
    pending_o = exp_q.size();
  end

endmodule

// File: dv/csr_input.txt
// 8 hex words per record, step number in the trailing comment, kind first
// 1 access: op(0 rw 1 rs 2 rc) addr operand rd_nz exp_rdata exp_illegal exp_written
// 2 trap: pc cause value exp_pc | 3 mret: exp_pc | 4 retire: count | 5 mcycle pair: min delta
1 0 340 a5a5f00f 1 00000000 0 1   // 0 rw mscratch
1 1 340 00000ff0 1 a5a5f00f 0 1   // 1 rs mscratch
1 2 340 0000000f 1 a5a5ffff 0 1   // 2 rc mscratch
1 1 340 00000000 1 a5a5fff0 0 0   // 3 rs zero operand
1 2 340 00000000 0 00000000 0 0   // 4 rc zero operand to x0
1 0 343 12345678 1 00000000 0 1   // 5 rw mtval
1 2 343 000000ff 0 00000000 0 1   // 6 rc mtval to x0
1 1 343 80000000 1 12345600 0 1   // 7 rs mtval
1 0 305 80000103 1 00000000 0 1   // 8 rw mtvec with low bits
1 1 305 00000000 1 80000100 0 0   // 9 mtvec read back aligned
2 80002046 0000000b 0000dead 80000100 0 0 0   // 10 trap entry
1 1 341 00000000 1 80002044 0 0   // 11 mepc after trap
1 1 342 00000000 1 0000000b 0 0   // 12 mcause after trap
1 1 343 00000000 1 0000dead 0 0   // 13 mtval after trap
3 80002044 0 0 0 0 0 0            // 14 mret after trap
1 0 341 80004000 1 80002044 0 1   // 15 rw mepc
3 80004000 0 0 0 0 0 0            // 16 mret after write
4 00000005 0 0 0 0 0 0            // 17 retire burst
4 00000007 0 0 0 0 0 0            // 18 retire burst
1 1 b02 00000000 1 0000000c 0 0   // 19 minstret
1 1 b82 00000000 1 00000000 0 0   // 20 minstreth
5 00000003 0 0 0 0 0 0            // 21 mcycle back to back
1 0 b02 00000100 1 00000000 1 0   // 22 write minstret
1 1 b02 00000000 1 0000000c 0 0   // 23 minstret unchanged
1 1 b80 00000001 1 00000000 1 0   // 24 set bits in mcycleh
1 0 7c0 ffffffff 1 00000000 1 0   // 25 unmapped rw
1 1 300 00000000 1 00000000 1 0   // 26 unmapped rs
0 0 0 0 0 0 0 0                   // end

// File: dv/csr_unit_tb.sv
`timescale 1ns/1ps

module csr_unit_tb;
  import csr_pkg::*;

  logic            clk = 1'b0;
  logic            rst;
  logic            req_valid;
  csr_req_t        req;
  logic            trap;
  logic [XLEN-1:0] trap_pc;
  logic [XLEN-1:0] trap_cause;
  logic [XLEN-1:0] trap_val;
  logic            retire;
  logic            done;
  csr_rsp_t        rsp;
  redirect_t       redirect;
  logic            busy;

  // hand-off to the checker
  logic            exp_push;
  logic [2:0]      exp_kind;
  logic [15:0]     exp_id;
  logic [XLEN-1:0] exp_data;
  logic            exp_illegal;
  logic            exp_written;
  logic [31:0]     chk_errors;
  logic [31:0]     chk_pending;

  // eight words per record of the data file
  logic [31:0]     stim_mem [0:511];
  int              timeout_errors;
  int              wait_limit = 20;

  always #4 clk = ~clk;

  csr_unit dut_i (
    .clk_i        (clk),
    .rst_i        (rst),
    .req_valid_i  (req_valid),
    .req_i        (req),
    .trap_i       (trap),
    .trap_pc_i    (trap_pc),
    .trap_cause_i (trap_cause),
    .trap_val_i   (trap_val),
    .retire_i     (retire),
    .done_o       (done),
    .rsp_o        (rsp),
    .redirect_o   (redirect),
    .busy_o       (busy)
  );

  csr_checker chk_i (
    .clk_i         (clk),
    .rst_i         (rst),
    .exp_push_i    (exp_push),
    .exp_kind_i    (exp_kind),
    .exp_id_i      (exp_id),
    .exp_data_i    (exp_data),
    .exp_illegal_i (exp_illegal),
    .exp_written_i (exp_written),
    .done_i        (done),
    .rsp_i         (rsp),
    .redirect_i    (redirect),
    .busy_i        (busy),
    .err_count_o   (chk_errors),
    .pending_o     (chk_pending)
  );

  //////////////////////////////////////////////////
  // bounded waits sampled on the falling edge
  //////////////////////////////////////////////////

  task automatic wait_for_done(input int id);
    int n = 0;
    while (!done && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (!done) begin
      $display("timeout at step %0d: done pulse never came", id);
      timeout_errors++;
    end
  endtask

  task automatic wait_for_redirect(input int id);
    int n = 0;
    while (!redirect.valid && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (!redirect.valid) begin
      $display("timeout at step %0d: redirect never came", id);
      timeout_errors++;
    end
  endtask

  task automatic wait_until_idle(input int id);
    int n = 0;
    while (busy && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (busy) begin
      $display("timeout at step %0d: unit stayed busy", id);
      timeout_errors++;
    end
  endtask

  //////////////////////////////////////////////////
  // stimulus tasks called on a falling edge
  //////////////////////////////////////////////////

  task automatic queue_expect(input int id, input logic [2:0] kind,
                              input logic [XLEN-1:0] data, input logic ill,
                              input logic wr);
    exp_push    = 1'b1;
    exp_kind    = kind;
    exp_id      = id[15:0];
    exp_data    = data;
    exp_illegal = ill;
    exp_written = wr;
  endtask

  task automatic run_access(input int id, input logic [1:0] op, input logic [11:0] addr,
                            input logic [XLEN-1:0] operand, input logic rd_nz,
                            input logic [2:0] kind, input logic [XLEN-1:0] e_data,
                            input logic e_ill, input logic e_wr);
    req_valid = 1'b1;
    req.op    = csr_op_e'(op);
    req.addr  = addr;
    req.wdata = operand;
    req.rd_nz = rd_nz;
    queue_expect(id, kind, e_data, e_ill, e_wr);
    @(negedge clk);
    req_valid = 1'b0;
    exp_push  = 1'b0;
    wait_for_done(id);
    wait_until_idle(id);
  endtask

  task automatic run_trap(input int id, input logic [XLEN-1:0] pc,
                          input logic [XLEN-1:0] cause, input logic [XLEN-1:0] val,
                          input logic [XLEN-1:0] e_pc);
    trap       = 1'b1;
    trap_pc    = pc;
    trap_cause = cause;
    trap_val   = val;
    queue_expect(id, 3'd2, e_pc, 1'b0, 1'b0);
    @(negedge clk);
    trap     = 1'b0;
    exp_push = 1'b0;
    wait_for_redirect(id);
    wait_until_idle(id);
  endtask

  task automatic run_retire(input logic [31:0] count);
    retire = 1'b1;
    repeat (count) @(negedge clk);
    retire = 1'b0;
  endtask

  initial begin : stimulus
    int   rec;
    int   base;
    logic finished;
    rst         = 1'b1;
    req_valid   = 1'b0;
    req         = '0;
    trap        = 1'b0;
    trap_pc     = '0;
    trap_cause  = '0;
    trap_val    = '0;
    retire      = 1'b0;
    exp_push    = 1'b0;
    exp_kind    = '0;
    exp_id      = '0;
    exp_data    = '0;
    exp_illegal = 1'b0;
    exp_written = 1'b0;
    timeout_errors = 0;
    $readmemh("dv/csr_input.txt", stim_mem);
    repeat (16) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    rec      = 0;
    finished = 1'b0;
    while (!finished && rec < 64) begin
      base = rec * 8;
      case (stim_mem[base])
        32'd1: run_access(rec, stim_mem[base+1][1:0], stim_mem[base+2][11:0],
                          stim_mem[base+3], stim_mem[base+4][0], 3'd1,
                          stim_mem[base+5], stim_mem[base+6][0], stim_mem[base+7][0]);
        32'd2: run_trap(rec, stim_mem[base+1], stim_mem[base+2], stim_mem[base+3],
                        stim_mem[base+4]);
        32'd3: run_access(rec, 2'd3, 12'h000, '0, 1'b1, 3'd3, stim_mem[base+1],
                          1'b0, 1'b0);
        32'd4: run_retire(stim_mem[base+1]);
        32'd5: begin
          // two mcycle reads back to back
          run_access(rec, 2'd1, CSR_MCYCLE, '0, 1'b1, 3'd5, '0, 1'b0, 1'b0);
          run_access(rec, 2'd1, CSR_MCYCLE, '0, 1'b1, 3'd6, stim_mem[base+1],
                     1'b0, 1'b0);
        end
        default: finished = 1'b1;
      endcase
      rec++;
    end
    wait_until_idle(rec);
    repeat (3) @(negedge clk);
    if (chk_pending != 0) begin
      $display("%0d expected responses never arrived", chk_pending);
      timeout_errors++;
    end
    $display("errors: %0d compare, %0d timeout or missing", chk_errors, timeout_errors);
    if (chk_errors == 0 && timeout_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: filelist.f
logic/csr_pkg.sv
logic/csr_counters.sv
logic/csr_trap_regs.sv
logic/csr_sequencer.sv
logic/csr_unit.sv
dv/csr_checker.sv
dv/csr_unit_tb.sv

// File: logic/csr_counters.sv
`timescale 1ns/1ps

module csr_counters (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     retire_i,
  input  csr_pkg::csr_addr_e       rd_addr_i,
  output logic [csr_pkg::XLEN-1:0] rdata_o,
  output logic                     hit_o
);
  import csr_pkg::*;

  logic [2*XLEN-1:0] mcycle_q;
  logic [2*XLEN-1:0] minstret_q;

  //////////////////////////////////////////////////
  // free running counters
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mcycle_q   <= '0;
      minstret_q <= '0;
    end else begin
      mcycle_q <= mcycle_q + 1'b1;
      // retire_i is a level, one count per high cycle
      if (retire_i) begin
        minstret_q <= minstret_q + 1'b1;
      end
    end
  end

  // read-out, split into low and high halves
  always_comb begin
    rdata_o = '0;
    hit_o   = 1'b1;
    case (rd_addr_i)
      CSR_MCYCLE:    rdata_o = mcycle_q[XLEN-1:0];
      CSR_MCYCLEH:   rdata_o = mcycle_q[2*XLEN-1:XLEN];
      CSR_MINSTRET:  rdata_o = minstret_q[XLEN-1:0];
      CSR_MINSTRETH: rdata_o = minstret_q[2*XLEN-1:XLEN];
      default:       hit_o = 1'b0;
    endcase
  end

  // cycle count only moves forward once out of reset
  mcycle_monotonic_a: assert property (
    @(posedge clk_i) disable iff (rst_i)
    !$past(rst_i) |-> (mcycle_q >= $past(mcycle_q))
  ) else $error("mcycle went backwards");

endmodule

// File: logic/csr_pkg.sv
package csr_pkg;

  //////////////////////////////////////////////////
  // widths and masks
  //////////////////////////////////////////////////

  localparam int XLEN = 32;

  // trap vector is word aligned, direct mode only
  localparam logic [XLEN-1:0] MTVEC_ALIGN_MASK = 32'hffff_fffc;

  //////////////////////////////////////////////////
  // csr map, opcodes, fsm states
  //////////////////////////////////////////////////

  typedef enum logic [11:0] {
    CSR_MTVEC     = 12'h305,
    CSR_MSCRATCH  = 12'h340,
    CSR_MEPC      = 12'h341,
    CSR_MCAUSE    = 12'h342,
    CSR_MTVAL     = 12'h343,
    CSR_MCYCLE    = 12'hB00,
    CSR_MINSTRET  = 12'hB02,
    CSR_MCYCLEH   = 12'hB80,
    CSR_MINSTRETH = 12'hB82
  } csr_addr_e;

  typedef enum logic [1:0] {
    CSR_RW   = 2'd0,
    CSR_RS   = 2'd1,
    CSR_RC   = 2'd2,
    CSR_MRET = 2'd3
  } csr_op_e;

  typedef enum logic [2:0] {
    ST_IDLE  = 3'd0,
    ST_READ  = 3'd1,
    ST_WRITE = 3'd2,
    ST_TRAP  = 3'd3,
    ST_RET   = 3'd4
  } csr_state_e;

  //////////////////////////////////////////////////
  // request, response and redirect bundles
  //////////////////////////////////////////////////

  // addr is raw so that unmapped addresses can reach the decode
  typedef struct packed {
    csr_op_e         op;
    logic [11:0]     addr;
    logic [XLEN-1:0] wdata;
    logic            rd_nz;
  } csr_req_t;

  typedef struct packed {
    logic [XLEN-1:0] rdata;
    logic            illegal;
    logic            written;
  } csr_rsp_t;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
  } redirect_t;

endpackage

// File: logic/csr_sequencer.sv
`timescale 1ns/1ps

module csr_sequencer (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     req_valid_i,
  input  csr_pkg::csr_req_t        req_i,
  input  logic                     trap_i,
  input  logic [csr_pkg::XLEN-1:0] trap_pc_i,
  input  logic [csr_pkg::XLEN-1:0] trap_cause_i,
  input  logic [csr_pkg::XLEN-1:0] trap_val_i,
  input  logic [csr_pkg::XLEN-1:0] trap_rdata_i,
  input  logic                     trap_hit_i,
  input  logic [csr_pkg::XLEN-1:0] cnt_rdata_i,
  input  logic                     cnt_hit_i,
  input  logic [csr_pkg::XLEN-1:0] mtvec_i,
  input  logic [csr_pkg::XLEN-1:0] mepc_i,
  output csr_pkg::csr_addr_e       rd_addr_o,
  output logic                     wr_en_o,
  output csr_pkg::csr_addr_e       wr_addr_o,
  output logic [csr_pkg::XLEN-1:0] wr_data_o,
  output logic                     trap_capture_o,
  output logic [csr_pkg::XLEN-1:0] trap_pc_o,
  output logic [csr_pkg::XLEN-1:0] trap_cause_o,
  output logic [csr_pkg::XLEN-1:0] trap_val_o,
  output logic                     done_o,
  output csr_pkg::csr_rsp_t        rsp_o,
  output csr_pkg::redirect_t       redirect_o,
  output logic                     busy_o
);
  import csr_pkg::*;

  csr_state_e      state_q;
  csr_state_e      state_d;
  csr_req_t        req_q;
  logic [XLEN-1:0] old_q;
  logic            hit_q;
  logic            is_cnt_q;
  logic [XLEN-1:0] trap_pc_q;
  logic [XLEN-1:0] trap_cause_q;
  logic [XLEN-1:0] trap_val_q;
  logic [XLEN-1:0] new_val;
  logic            do_write;
  logic            illegal;

  //////////////////////////////////////////////////
  // state machine
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        // trap wins over a request in the same cycle
        if (trap_i) begin
          state_d = ST_TRAP;
        end else if (req_valid_i) begin
          state_d = (req_i.op == CSR_MRET) ? ST_RET : ST_READ;
        end
      end
      ST_READ: state_d = ST_WRITE;
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // request, trap fields and old value
  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE && req_valid_i) begin
      req_q <= req_i;
    end
    if (state_q == ST_IDLE && trap_i) begin
      trap_pc_q    <= trap_pc_i;
      trap_cause_q <= trap_cause_i;
      trap_val_q   <= trap_val_i;
    end
    if (state_q == ST_READ) begin
      hit_q    <= trap_hit_i || cnt_hit_i;
      is_cnt_q <= cnt_hit_i;
      // counters drive zero on a miss
      old_q    <= trap_hit_i ? trap_rdata_i : cnt_rdata_i;
    end
  end

  //////////////////////////////////////////////////
  // modify step
  //////////////////////////////////////////////////

  always_comb begin
    case (req_q.op)
      CSR_RS:  new_val = old_q | req_q.wdata;
      CSR_RC:  new_val = old_q & ~req_q.wdata;
      default: new_val = req_q.wdata;
    endcase
  end

  // set/clear with a zero operand is a pure read
  assign do_write = (req_q.op == CSR_RW) || (req_q.wdata != '0);
  assign illegal  = !hit_q || (is_cnt_q && do_write);

  assign rd_addr_o = csr_addr_e'(req_q.addr);
  assign wr_addr_o = csr_addr_e'(req_q.addr);
  assign wr_data_o = new_val;
  assign wr_en_o   = (state_q == ST_WRITE) && do_write && !illegal;

  assign trap_capture_o = (state_q == ST_TRAP);
  assign trap_pc_o      = trap_pc_q;
  assign trap_cause_o   = trap_cause_q;
  assign trap_val_o     = trap_val_q;

  assign busy_o = (state_q != ST_IDLE);
  assign done_o = (state_q == ST_WRITE) || (state_q == ST_RET);

  always_comb begin
    rsp_o      = '0;
    redirect_o = '0;
    if (state_q == ST_WRITE) begin
      rsp_o.illegal = illegal;
      rsp_o.written = wr_en_o;
      rsp_o.rdata   = (req_q.rd_nz && !illegal) ? old_q : '0;
    end
    if (state_q == ST_TRAP) begin
      redirect_o.valid = 1'b1;
      redirect_o.pc    = mtvec_i;
    end
    if (state_q == ST_RET) begin
      redirect_o.valid = 1'b1;
      redirect_o.pc    = mepc_i;
    end
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  state_legal_a: assert property (
    @(posedge clk_i) disable iff (rst_i)
    state_q inside {ST_IDLE, ST_READ, ST_WRITE, ST_TRAP, ST_RET}
  ) else $error("sequencer in an undefined state");

  // the register bank must never see both update sources at once
  wr_trap_onehot_a: assert property (
    @(posedge clk_i) disable iff (rst_i)
    !(wr_en_o && trap_capture_o)
  ) else $error("csr write and trap capture in the same cycle");

  req_while_busy_a: assert property (
    @(posedge clk_i) disable iff (rst_i)
    req_valid_i |-> !busy_o
  ) else $error("request strobe while busy, dropped");

endmodule

// File: logic/csr_trap_regs.sv
`timescale 1ns/1ps

module csr_trap_regs (
  input  logic                     clk_i,
  input  logic                     rst_i,
  // read port
  input  csr_pkg::csr_addr_e       rd_addr_i,
  output logic [csr_pkg::XLEN-1:0] rdata_o,
  output logic                     hit_o,
  // csr write port
  input  logic                     wr_en_i,
  input  csr_pkg::csr_addr_e       wr_addr_i,
  input  logic [csr_pkg::XLEN-1:0] wr_data_i,
  // trap entry
  input  logic                     trap_capture_i,
  input  logic [csr_pkg::XLEN-1:0] trap_pc_i,
  input  logic [csr_pkg::XLEN-1:0] trap_cause_i,
  input  logic [csr_pkg::XLEN-1:0] trap_val_i,
  // redirect targets
  output logic [csr_pkg::XLEN-1:0] mtvec_o,
  output logic [csr_pkg::XLEN-1:0] mepc_o
);
  import csr_pkg::*;

  logic [XLEN-1:0] mtvec_q;
  logic [XLEN-1:0] mscratch_q;
  logic [XLEN-1:0] mepc_q;
  logic [XLEN-1:0] mcause_q;
  logic [XLEN-1:0] mtval_q;

  //////////////////////////////////////////////////
  // register updates
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mtvec_q    <= '0;
      mscratch_q <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
      mtval_q    <= '0;
    end else begin
      if (wr_en_i) begin
        case (wr_addr_i)
          CSR_MTVEC:    mtvec_q <= wr_data_i & MTVEC_ALIGN_MASK;
          CSR_MSCRATCH: mscratch_q <= wr_data_i;
          CSR_MEPC:     mepc_q <= wr_data_i;
          CSR_MCAUSE:   mcause_q <= wr_data_i;
          CSR_MTVAL:    mtval_q <= wr_data_i;
          default:      ;
        endcase
      end
      // the sequencer never issues a write in the same cycle
      if (trap_capture_i) begin
        mepc_q   <= {trap_pc_i[XLEN-1:2], 2'b00};
        mcause_q <= trap_cause_i;
        mtval_q  <= trap_val_i;
      end
    end
  end

  // read decode
  always_comb begin
    rdata_o = '0;
    hit_o   = 1'b1;
    case (rd_addr_i)
      CSR_MTVEC:    rdata_o = mtvec_q;
      CSR_MSCRATCH: rdata_o = mscratch_q;
      CSR_MEPC:     rdata_o = mepc_q;
      CSR_MCAUSE:   rdata_o = mcause_q;
      CSR_MTVAL:    rdata_o = mtval_q;
      default:      hit_o = 1'b0;
    endcase
  end

  assign mtvec_o = mtvec_q;
  assign mepc_o  = mepc_q;

  mtvec_aligned_a: assert property (
    @(posedge clk_i) disable iff (rst_i)
    mtvec_q[1:0] == 2'b00
  ) else $error("mtvec lost its alignment");

endmodule

// File: logic/csr_unit.sv
`timescale 1ns/1ps

module csr_unit (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     req_valid_i,
  input  csr_pkg::csr_req_t        req_i,
  input  logic                     trap_i,
  input  logic [csr_pkg::XLEN-1:0] trap_pc_i,
  input  logic [csr_pkg::XLEN-1:0] trap_cause_i,
  input  logic [csr_pkg::XLEN-1:0] trap_val_i,
  input  logic                     retire_i,
  output logic                     done_o,
  output csr_pkg::csr_rsp_t        rsp_o,
  output csr_pkg::redirect_t       redirect_o,
  output logic                     busy_o
);
  import csr_pkg::*;

  csr_addr_e       rd_addr;
  csr_addr_e       wr_addr;
  logic            wr_en;
  logic [XLEN-1:0] wr_data;
  logic            trap_capture;
  logic [XLEN-1:0] cap_pc;
  logic [XLEN-1:0] cap_cause;
  logic [XLEN-1:0] cap_val;
  logic [XLEN-1:0] trap_rdata;
  logic            trap_hit;
  logic [XLEN-1:0] cnt_rdata;
  logic            cnt_hit;
  logic [XLEN-1:0] mtvec;
  logic [XLEN-1:0] mepc;

  csr_sequencer seq_i (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .req_valid_i    (req_valid_i),
    .req_i          (req_i),
    .trap_i         (trap_i),
    .trap_pc_i      (trap_pc_i),
    .trap_cause_i   (trap_cause_i),
    .trap_val_i     (trap_val_i),
    .trap_rdata_i   (trap_rdata),
    .trap_hit_i     (trap_hit),
    .cnt_rdata_i    (cnt_rdata),
    .cnt_hit_i      (cnt_hit),
    .mtvec_i        (mtvec),
    .mepc_i         (mepc),
    .rd_addr_o      (rd_addr),
    .wr_en_o        (wr_en),
    .wr_addr_o      (wr_addr),
    .wr_data_o      (wr_data),
    .trap_capture_o (trap_capture),
    .trap_pc_o      (cap_pc),
    .trap_cause_o   (cap_cause),
    .trap_val_o     (cap_val),
    .done_o         (done_o),
    .rsp_o          (rsp_o),
    .redirect_o     (redirect_o),
    .busy_o         (busy_o)
  );

  // read-only counters share the read address
  csr_counters cnt_i (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .retire_i  (retire_i),
    .rd_addr_i (rd_addr),
    .rdata_o   (cnt_rdata),
    .hit_o     (cnt_hit)
  );

  csr_trap_regs regs_i (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .rd_addr_i      (rd_addr),
    .rdata_o        (trap_rdata),
    .hit_o          (trap_hit),
    .wr_en_i        (wr_en),
    .wr_addr_i      (wr_addr),
    .wr_data_i      (wr_data),
    .trap_capture_i (trap_capture),
    .trap_pc_i      (cap_pc),
    .trap_cause_i   (cap_cause),
    .trap_val_i     (cap_val),
    .mtvec_o        (mtvec),
    .mepc_o         (mepc)
  );

endmodule
